/* sdlx_consts.svh */
//************************************************************
// widths and instruction field positions for the execution core
// fields sit at fixed spots, bits 18..16 of a word are unused
// all operand and result words are SDLX_DATA_W wide
//************************************************************
`ifndef SDLX_CONSTS_SVH
`define SDLX_CONSTS_SVH

// data path and register file size
`define SDLX_DATA_W     32
`define SDLX_NUM_REGS   8
`define SDLX_RADDR_W    3

// opcode, top nibble of the instruction word
`define SDLX_OPC_W      4
`define SDLX_OPC_MSB    31
`define SDLX_OPC_LSB    28

// destination and source register numbers
`define SDLX_DST_MSB    27
`define SDLX_DST_LSB    25
`define SDLX_SRC1_MSB   24
`define SDLX_SRC1_LSB   22
`define SDLX_SRC2_MSB   21
`define SDLX_SRC2_LSB   19

// immediate, bottom half of the word
`define SDLX_IMM_W      16
`define SDLX_IMM_MSB    15
`define SDLX_IMM_LSB    0

`endif

/* sdlxPkg.sv */
//************************************************************
// shared vector types and the ALU operation encoding
// opcodes 10 to 15 are no-ops and never write a register
//************************************************************
`include "sdlx_consts.svh"

package sdlxPkg;

        // one data word, also the width of every operand
        typedef logic [`SDLX_DATA_W-1:0] dataT;

        // register number, r0 reads as zero
        typedef logic [`SDLX_RADDR_W-1:0] regAddrT;

        // raw instruction word as strobed in
        typedef logic [`SDLX_DATA_W-1:0] instrT;

        // immediate field before sign extension
        typedef logic [`SDLX_IMM_W-1:0] immT;

        // ALU operation, taken straight from the opcode field
        typedef enum logic [`SDLX_OPC_W-1:0] {
                opAdd  = 4'd0,
                opSub  = 4'd1,
                opAnd  = 4'd2,
                opOr   = 4'd3,
                opXor  = 4'd4,
                opSlt  = 4'd5,
                opSll  = 4'd6,
                opSrl  = 4'd7,
                opAddi = 4'd8,
                opLhi  = 4'd9
        } aluOpT;

endpackage

/* regReadIf.sv */
//************************************************************
// two register read ports, answered combinationally
// data belongs to the address in the same cycle
//************************************************************
`timescale 1ns/1ps

interface regReadIf;

        // read addresses from the decoder
        sdlxPkg::regAddrT rdAddrA;
        sdlxPkg::regAddrT rdAddrB;

        // read data back from the register file
        sdlxPkg::dataT rdDataA;
        sdlxPkg::dataT rdDataB;

        // operand side drives the addresses
        modport reader (
                output rdAddrA,
                output rdAddrB,
                input  rdDataA,
                input  rdDataB
        );

        // register file side answers with data
        modport file (
                input  rdAddrA,
                input  rdAddrB,
                output rdDataA,
                output rdDataB
        );

endinterface

/* regFile.sv */
//************************************************************
// eight registers, one write port, two read ports
// r0 is not stored and always reads as zero
// a read of the register being written sees the new data
//************************************************************
`timescale 1ns/1ps
`include "sdlx_consts.svh"

module regFile (
        input  logic             Clk,
        input  logic             rstN,
        regReadIf.file           rd,
        input  logic             wrEn,
        input  sdlxPkg::regAddrT wrReg,
        input  sdlxPkg::dataT    wrData
);

        // only r1..r7 are real storage
        sdlxPkg::dataT [`SDLX_NUM_REGS-1:1] regs;

        // read mux with r0 forced and write-through bypass
        function automatic sdlxPkg::dataT readReg(input sdlxPkg::regAddrT addr);
                sdlxPkg::dataT val;
                if (addr == '0) begin
                        val = '0;
                end else if (wrEn && (wrReg == addr)) begin
                        // same-cycle write wins over the stored copy
                        val = wrData;
                end else begin
                        val = regs[addr];
                end
                return val;
        endfunction

        //************************************************************
        // storage
        //************************************************************

        always_ff @(posedge Clk) begin
                if (!rstN) begin
                        regs <= '0;
                end else if (wrEn && (wrReg != '0)) begin
                        regs[wrReg] <= wrData;
                end
        end

        //************************************************************
        // read ports
        //************************************************************

        always_comb begin
                rd.rdDataA = readReg(rd.rdAddrA);
                rd.rdDataB = readReg(rd.rdAddrB);
        end

        // a write aimed at r0 must leave every stored register alone
        r0WriteIgnored: assert property (@(posedge Clk) disable iff (!rstN)
                (wrEn && (wrReg == '0)) |=> $stable(regs))
                else $error("regFile: write to r0 changed the array");

endmodule

/* operandStage.sv */
//************************************************************
// decode, operand fetch with forwarding, operand latch
// one cycle from instrValid to opValid
// forwarding covers only the instruction now in the ALU,
// older results come through the register file bypass
//************************************************************
`timescale 1ns/1ps
`include "sdlx_consts.svh"

module operandStage (
        input  logic              Clk,
        input  logic              rstN,
        input  logic              instrValid,
        input  sdlxPkg::instrT    instrWord,
        regReadIf.reader          rd,
        input  sdlxPkg::dataT     aluResult,
        input  logic              exValid,
        input  sdlxPkg::regAddrT  exReg,
        output logic              opValid,
        output sdlxPkg::aluOpT    op,
        output sdlxPkg::regAddrT  dstReg,
        output sdlxPkg::dataT     opA,
        output sdlxPkg::dataT     opB
);

        // decoded fields
        sdlxPkg::aluOpT   decOp;
        sdlxPkg::regAddrT decDst;
        sdlxPkg::regAddrT decSrc1;
        sdlxPkg::regAddrT decSrc2;
        sdlxPkg::immT     decImm;

        // operands after forwarding and immediate select
        sdlxPkg::dataT    srcA;
        sdlxPkg::dataT    srcB;
        sdlxPkg::dataT    immExt;

        //************************************************************
        // decode
        //************************************************************

        assign decOp   = sdlxPkg::aluOpT'(instrWord[`SDLX_OPC_MSB:`SDLX_OPC_LSB]);
        assign decDst  = instrWord[`SDLX_DST_MSB:`SDLX_DST_LSB];
        assign decSrc1 = instrWord[`SDLX_SRC1_MSB:`SDLX_SRC1_LSB];
        assign decSrc2 = instrWord[`SDLX_SRC2_MSB:`SDLX_SRC2_LSB];
        assign decImm  = instrWord[`SDLX_IMM_MSB:`SDLX_IMM_LSB];

        // sign extend, LHI only looks at the low half later
        assign immExt = {{(`SDLX_DATA_W-`SDLX_IMM_W){decImm[`SDLX_IMM_W-1]}}, decImm};

        // register reads go out every cycle, valid or not
        assign rd.rdAddrA = decSrc1;
        assign rd.rdAddrB = decSrc2;

        //************************************************************
        // forwarding and operand select
        //************************************************************

        always_comb begin
                // source one, ALU result if it targets the same register
                if (exValid && (exReg == decSrc1) && (decSrc1 != '0)) begin
                        srcA = aluResult;
                end else begin
                        srcA = rd.rdDataA;
                end
                // source two, immediate forms ignore the register
                if ((decOp == sdlxPkg::opAddi) || (decOp == sdlxPkg::opLhi)) begin
                        srcB = immExt;
                end else if (exValid && (exReg == decSrc2) && (decSrc2 != '0)) begin
                        srcB = aluResult;
                end else begin
                        srcB = rd.rdDataB;
                end
        end

        // control flag
        always_ff @(posedge Clk) begin
                if (!rstN) begin
                        opValid <= 1'b0;
                end else begin
                        opValid <= instrValid;
                end
        end

        // operand latch, payload only
        always_ff @(posedge Clk) begin
                op     <= decOp;
                dstReg <= decDst;
                opA    <= srcA;
                opB    <= srcB;
        end

endmodule

/* aluExec.sv */
//************************************************************
// ALU plus the write-back request register
// one cycle from opValid to wbValid
// no-ops and writes to r0 never raise wbValid
//************************************************************
`timescale 1ns/1ps
`include "sdlx_consts.svh"

module aluExec (
        input  logic              Clk,
        input  logic              rstN,
        input  logic              opValid,
        input  sdlxPkg::aluOpT    op,
        input  sdlxPkg::regAddrT  dstReg,
        input  sdlxPkg::dataT     opA,
        input  sdlxPkg::dataT     opB,
        output sdlxPkg::dataT     aluResult,
        output logic              exValid,
        output sdlxPkg::regAddrT  exReg,
        output logic              wbValid,
        output sdlxPkg::regAddrT  wbReg,
        output sdlxPkg::dataT     wbData
);

        // set for the ten real operations
        logic writesReg;

        //************************************************************
        // operation decode
        //************************************************************

        always_comb begin
                aluResult = '0;
                writesReg = 1'b1;
                case (op)
                        sdlxPkg::opAdd:  aluResult = opA + opB;
                        sdlxPkg::opSub:  aluResult = opA - opB;
                        sdlxPkg::opAnd:  aluResult = opA & opB;
                        sdlxPkg::opOr:   aluResult = opA | opB;
                        sdlxPkg::opXor:  aluResult = opA ^ opB;
                        // signed compare, result is 0 or 1
                        sdlxPkg::opSlt:  aluResult[0] = ($signed(opA) < $signed(opB));
                        // shift amount is the low five bits of B
                        sdlxPkg::opSll:  aluResult = opA << opB[4:0];
                        sdlxPkg::opSrl:  aluResult = opA >> opB[4:0];
                        sdlxPkg::opAddi: aluResult = opA + opB;
                        // immediate into the upper half, low half cleared
                        sdlxPkg::opLhi:  aluResult = {opB[`SDLX_IMM_W-1:0],
                                                      {`SDLX_IMM_W{1'b0}}};
                        default:         writesReg = 1'b0;
                endcase
        end

        // forwarding view of the instruction in flight
        assign exReg   = dstReg;
        assign exValid = opValid && writesReg && (dstReg != '0);

        //************************************************************
        // write-back request
        //************************************************************

        always_ff @(posedge Clk) begin
                if (!rstN) begin
                        wbValid <= 1'b0;
                end else begin
                        wbValid <= exValid;
                end
        end

        always_ff @(posedge Clk) begin
                wbReg  <= exReg;
                wbData <= aluResult;
        end

        // operands fetched from a cleared file must never give X here
        wbDataKnown: assert property (@(posedge Clk) disable iff (!rstN)
                wbValid |-> !$isunknown(wbData))
                else $error("aluExec: unknown wbData on write-back");

endmodule

/* wbArbiter.sv */
//************************************************************
// fixed-priority owner of the register write port
// order: ALU write-back, held host write, new host write
// host must idle one cycle between writes, hold is one deep
//************************************************************
`timescale 1ns/1ps

module wbArbiter (
        input  logic              Clk,
        input  logic              rstN,
        input  logic              wbValid,
        input  sdlxPkg::regAddrT  wbReg,
        input  sdlxPkg::dataT     wbData,
        input  logic              hostWrValid,
        input  sdlxPkg::regAddrT  hostWrReg,
        input  sdlxPkg::dataT     hostWrData,
        output logic              wrEn,
        output sdlxPkg::regAddrT  wrReg,
        output sdlxPkg::dataT     wrData
);

        // host write that lost against a write-back
        logic             holdValid;
        sdlxPkg::regAddrT holdReg;
        sdlxPkg::dataT    holdData;

        //************************************************************
        // grant
        //************************************************************

        always_comb begin
                wrEn   = 1'b0;
                wrReg  = wbReg;
                wrData = wbData;
                if (wbValid) begin
                        wrEn = 1'b1;
                end else if (holdValid) begin
                        wrEn   = 1'b1;
                        wrReg  = holdReg;
                        wrData = holdData;
                end else if (hostWrValid) begin
                        wrEn   = 1'b1;
                        wrReg  = hostWrReg;
                        wrData = hostWrData;
                end
        end

        //************************************************************
        // hold register
        //************************************************************

        // fill on a collision, drain on the first free cycle
        always_ff @(posedge Clk) begin
                if (!rstN) begin
                        holdValid <= 1'b0;
                end else if (hostWrValid && wbValid) begin
                        holdValid <= 1'b1;
                end else if (!wbValid) begin
                        holdValid <= 1'b0;
                end
        end

        always_ff @(posedge Clk) begin
                if (hostWrValid && wbValid) begin
                        holdReg  <= hostWrReg;
                        holdData <= hostWrData;
                end
        end

        // host may only write while nothing is held
        holdNoOverwrite: assert property (@(posedge Clk) disable iff (!rstN)
                hostWrValid |-> !holdValid)
                else $error("wbArbiter: host write while hold is full");

        // a host write that lost is written on the next free cycle
        holdDrains: assert property (@(posedge Clk) disable iff (!rstN)
                ($past(hostWrValid && wbValid) && !wbValid) |->
                (wrEn && (wrReg == $past(hostWrReg)) && (wrData == $past(hostWrData))))
                else $error("wbArbiter: held write not granted");

        // host strobes need an idle cycle in between
        hostIdleGap: assert property (@(posedge Clk) disable iff (!rstN)
                hostWrValid |=> !hostWrValid)
                else $error("wbArbiter: back-to-back host writes");

endmodule

/* sdlxDatapath.sv */
//************************************************************
// integer execution core top, plain ports only
// resultValid comes exactly two cycles after instrValid
// host writes may be delayed by write-back collisions
//************************************************************
`timescale 1ns/1ps
`include "sdlx_consts.svh"

module sdlxDatapath (
        input  logic                      Clk,
        input  logic                      rstN,
        input  logic                      instrValid,
        input  logic [`SDLX_DATA_W-1:0]   instrWord,
        input  logic                      hostWrValid,
        input  logic [`SDLX_RADDR_W-1:0]  hostWrReg,
        input  logic [`SDLX_DATA_W-1:0]   hostWrData,
        output logic                      resultValid,
        output logic [`SDLX_RADDR_W-1:0]  resultReg,
        output logic [`SDLX_DATA_W-1:0]   resultData
);

        // operand latch to ALU
        logic             opValid;
        sdlxPkg::aluOpT   op;
        sdlxPkg::regAddrT dstReg;
        sdlxPkg::dataT    opA;
        sdlxPkg::dataT    opB;

        // forwarding from the ALU
        sdlxPkg::dataT    aluResult;
        logic             exValid;
        sdlxPkg::regAddrT exReg;

        // write-back request and granted write
        logic             wbValid;
        sdlxPkg::regAddrT wbReg;
        sdlxPkg::dataT    wbData;
        logic             wrEn;
        sdlxPkg::regAddrT wrReg;
        sdlxPkg::dataT    wrData;

        regReadIf rdBus ();

        regFile regFileInst (
                .Clk(Clk), .rstN(rstN), .rd(rdBus.file),
                .wrEn(wrEn), .wrReg(wrReg), .wrData(wrData)
        );

        operandStage operandStageInst (
                .Clk(Clk), .rstN(rstN), .instrValid(instrValid),
                .instrWord(instrWord), .rd(rdBus.reader),
                .aluResult(aluResult), .exValid(exValid), .exReg(exReg),
                .opValid(opValid), .op(op), .dstReg(dstReg), .opA(opA), .opB(opB)
        );

        aluExec aluExecInst (
                .Clk(Clk), .rstN(rstN), .opValid(opValid), .op(op),
                .dstReg(dstReg), .opA(opA), .opB(opB), .aluResult(aluResult),
                .exValid(exValid), .exReg(exReg),
                .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
        );

        wbArbiter wbArbiterInst (
                .Clk(Clk), .rstN(rstN),
                .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
                .hostWrValid(hostWrValid), .hostWrReg(hostWrReg),
                .hostWrData(hostWrData),
                .wrEn(wrEn), .wrReg(wrReg), .wrData(wrData)
        );

        // retire strobe is the write-back request itself
        assign resultValid = wbValid;
        assign resultReg   = wbReg;
        assign resultData  = wbData;

endmodule

/* tbSdlx.sv */
//************************************************************
// self-checking testbench for the integer execution core
// expected results come from a program-order register model
// host writes keep a three cycle distance to any reader
//************************************************************
`timescale 1ns/1ps
`include "sdlx_consts.svh"

module tbSdlx;

        // cycle budget per test section, doubled for the timeout
        localparam int resetCycles   = 10;
        localparam int hostCycles    = 7 * 2 + 3 + 7;
        localparam int aluCycles     = 16 * 8;
        localparam int forwardCycles = 12 + 3 + 12 * 2 + 3;
        localparam int zeroCycles    = 2 + 2 + 3 + 2 + 3;
        localparam int collideCycles = 1 + 1 + 2 + 3 + 2 + 8;
        localparam int cycleLimit    = 2 * (resetCycles + hostCycles + aluCycles
                                            + forwardCycles + zeroCycles + collideCycles);

        logic                     Clk;
        logic                     rstN;
        logic                     instrValid;
        logic [`SDLX_DATA_W-1:0]  instrWord;
        logic                     hostWrValid;
        logic [`SDLX_RADDR_W-1:0] hostWrReg;
        logic [`SDLX_DATA_W-1:0]  hostWrData;
        logic                     resultValid;
        logic [`SDLX_RADDR_W-1:0] resultReg;
        logic [`SDLX_DATA_W-1:0]  resultData;

        // architectural register state in program order
        logic [`SDLX_DATA_W-1:0]  model [0:`SDLX_NUM_REGS-1];

        // expectation pipeline, stage 3 lines up with resultValid
        logic                     exp1Valid, exp2Valid, exp3Valid;
        logic [`SDLX_RADDR_W-1:0] exp1Reg, exp2Reg, exp3Reg;
        logic [`SDLX_DATA_W-1:0]  exp1Data, exp2Data, exp3Data;
        string                    exp1Name, exp2Name, exp3Name;

        int seed;
        int errorCount;
        int resultCount;
        int cycleCount;

        sdlxDatapath sdlxDatapath_inst (
                .Clk(Clk), .rstN(rstN), .instrValid(instrValid), .instrWord(instrWord),
                .hostWrValid(hostWrValid), .hostWrReg(hostWrReg), .hostWrData(hostWrData),
                .resultValid(resultValid), .resultReg(resultReg), .resultData(resultData)
        );

        initial Clk = 1'b0;
        always #2 Clk = ~Clk;

        //************************************************************
        // reference rules and random helpers
        //************************************************************

        // result of one operation on already selected operands
        function automatic logic [`SDLX_DATA_W-1:0] refResult(input logic [3:0] opc,
                                                              input logic [`SDLX_DATA_W-1:0] a,
                                                              input logic [`SDLX_DATA_W-1:0] b);
                logic [`SDLX_DATA_W-1:0] r;
                case (opc)
                        4'd0:    r = a + b;
                        4'd1:    r = a - b;
                        4'd2:    r = a & b;
                        4'd3:    r = a | b;
                        4'd4:    r = a ^ b;
                        4'd5:    r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        4'd6:    r = a << b[4:0];
                        4'd7:    r = a >> b[4:0];
                        4'd8:    r = a + b;
                        4'd9:    r = {b[15:0], 16'h0000};
                        default: r = 32'd0;
                endcase
                return r;
        endfunction

        function automatic logic [`SDLX_DATA_W-1:0] randWord();
                return $random(seed);
        endfunction

        function automatic logic [15:0] randImm();
                logic [`SDLX_DATA_W-1:0] w;
                w = $random(seed);
                return w[15:0];
        endfunction

        function automatic logic [`SDLX_RADDR_W-1:0] randReg();
                logic [`SDLX_DATA_W-1:0] w;
                w = $random(seed);
                return w[2:0];
        endfunction

        //************************************************************
        // stimulus tasks
        //************************************************************

        // step to the next falling edge and age the expectations
        task automatic nextCycle();
                @(negedge Clk);
                exp3Valid = exp2Valid;
                exp3Reg = exp2Reg;
                exp3Data = exp2Data;
                exp3Name = exp2Name;
                exp2Valid = exp1Valid;
                exp2Reg = exp1Reg;
                exp2Data = exp1Data;
                exp2Name = exp1Name;
                exp1Valid = 1'b0;
                instrValid = 1'b0;
                hostWrValid = 1'b0;
        endtask

        task automatic idle(input int n);
                repeat (n) nextCycle();
        endtask

        // one host write followed by the mandatory idle cycle
        task automatic hostWrite(input logic [`SDLX_RADDR_W-1:0] r,
                                 input logic [`SDLX_DATA_W-1:0] d);
                nextCycle();
                hostWrValid = 1'b1;
                hostWrReg = r;
                hostWrData = d;
                // r0 stays zero whatever the host sends
                if (r != '0) begin
                        model[r] = d;
                end
                nextCycle();
        endtask

        // strobe one instruction and record what it must retire
        task automatic issue(input logic [3:0] opc, input logic [`SDLX_RADDR_W-1:0] dst,
                             input logic [`SDLX_RADDR_W-1:0] s1,
                             input logic [`SDLX_RADDR_W-1:0] s2,
                             input logic [15:0] imm, input string name);
                logic [`SDLX_DATA_W-1:0] a;
                logic [`SDLX_DATA_W-1:0] b;
                logic [`SDLX_DATA_W-1:0] res;
                nextCycle();
                a = model[s1];
                if ((opc == 4'd8) || (opc == 4'd9)) begin
                        b = {{16{imm[15]}}, imm};
                end else begin
                        b = model[s2];
                end
                res = refResult(opc, a, b);
                instrValid = 1'b1;
                instrWord = {opc, dst, s1, s2, 3'b000, imm};
                exp1Name = name;
                // no-ops and r0 targets retire nothing
                if ((opc <= 4'd9) && (dst != 3'd0)) begin
                        exp1Valid = 1'b1;
                        exp1Reg = dst;
                        exp1Data = res;
                        model[dst] = res;
                end
        endtask

        //************************************************************
        // checks
        //************************************************************

        validCheck: assert property (@(posedge Clk) disable iff (!rstN)
                resultValid == exp3Valid)
                else begin
                        errorCount++;
                        $display("Mismatch %s resultValid expected %0b actual %0b",
                                 exp3Name, exp3Valid, $sampled(resultValid));
                end

        regCheck: assert property (@(posedge Clk) disable iff (!rstN)
                resultValid |-> (resultReg == exp3Reg))
                else begin
                        errorCount++;
                        $display("Mismatch %s resultReg expected %0d actual %0d",
                                 exp3Name, exp3Reg, $sampled(resultReg));
                end

        dataCheck: assert property (@(posedge Clk) disable iff (!rstN)
                resultValid |-> (resultData == exp3Data))
                else begin
                        errorCount++;
                        $display("Mismatch %s resultData expected %08h actual %08h",
                                 exp3Name, exp3Data, $sampled(resultData));
                end

        // result counter and run limit
        always @(posedge Clk) begin
                if (rstN && resultValid) begin
                        resultCount++;
                end
                cycleCount++;
                if (cycleCount > cycleLimit) begin
                        $display("timeout after %0d cycles, stimulus did not finish", cycleLimit);
                        $display("*** FAILED ***");
                        $finish;
                end
        end

        //************************************************************
        // test sequence
        //************************************************************

        initial begin
                logic [`SDLX_RADDR_W-1:0] prevDst;
                logic [`SDLX_RADDR_W-1:0] dst;
                logic [`SDLX_DATA_W-1:0]  w;
                seed = 29242;
                errorCount = 0;
                resultCount = 0;
                cycleCount = 0;
                rstN = 1'b0;
                instrValid = 1'b0;
                instrWord = '0;
                hostWrValid = 1'b0;
                hostWrReg = '0;
                hostWrData = '0;
                exp1Valid = 1'b0;
                exp2Valid = 1'b0;
                exp3Valid = 1'b0;
                exp1Reg = '0;
                exp2Reg = '0;
                exp3Reg = '0;
                exp1Data = '0;
                exp2Data = '0;
                exp3Data = '0;
                exp1Name = "reset";
                exp2Name = "reset";
                exp3Name = "reset";
                for (int r = 0; r < `SDLX_NUM_REGS; r++) begin
                        model[r] = '0;
                end
                repeat (8) @(posedge Clk);
                nextCycle();
                rstN = 1'b1;
                idle(2);

                // host load of r1..r7, read back through ADD rd, rs, r0
                for (int r = 1; r < `SDLX_NUM_REGS; r++) begin
                        hostWrite(3'(r), randWord());
                end
                idle(3);
                for (int r = 1; r < `SDLX_NUM_REGS; r++) begin
                        issue(4'd0, 3'(r), 3'(r), 3'd0, 16'h0000, "host load");
                end
                idle(3);

                // every opcode on fresh operands, 10..15 are no-ops
                for (int k = 0; k < 16; k++) begin
                        hostWrite(3'd1, randWord());
                        hostWrite(3'd2, randWord());
                        idle(3);
                        issue(4'(k), 3'd3, 3'd1, 3'd2, randImm(), $sformatf("alu op %0d", k));
                end
                idle(3);

                // dependent chain every cycle, then with a one cycle gap
                prevDst = 3'd3;
                for (int k = 0; k < 24; k++) begin
                        w = randWord();
                        dst = randReg();
                        if (dst == 3'd0) begin
                                dst = 3'd1;
                        end
                        if (k < 12) begin
                                issue(4'(w % 32'd10), dst, prevDst, randReg(), randImm(),
                                      "forward back to back");
                        end else begin
                                issue(4'(w % 32'd10), dst, prevDst, randReg(), randImm(),
                                      "forward gap");
                                idle(1);
                        end
                        prevDst = dst;
                end
                idle(3);

                // r0 as target retires nothing and still reads zero
                issue(4'd0, 3'd0, 3'd1, 3'd2, 16'h0000, "r0 target");
                issue(4'd8, 3'd0, 3'd1, 3'd0, randImm(), "r0 target");
                // host write aimed at r0 is dropped as well
                hostWrite(3'd0, randWord());
                idle(3);
                issue(4'd3, 3'd4, 3'd0, 3'd0, 16'h0000, "r0 read");
                issue(4'd8, 3'd5, 3'd0, 3'd0, randImm(), "r0 read");
                idle(3);

                // host write lands in the write-back cycle of another register
                issue(4'd1, 3'd4, 3'd1, 3'd2, 16'h0000, "collision write-back");
                idle(1);
                hostWrite(3'd5, randWord());
                idle(3);
                issue(4'd0, 3'd6, 3'd4, 3'd0, 16'h0000, "collision read");
                issue(4'd0, 3'd7, 3'd5, 3'd0, 16'h0000, "collision read");
                idle(5);

                $display("closing: %0d errors, %0d results checked", errorCount, resultCount);
                if (errorCount == 0) begin
                        $display("*** PASSED ***");
                end else begin
                        $display("*** FAILED ***");
                end
                $finish;
        end

endmodule

/* sources.f */
+incdir+.
sdlxPkg.sv
regReadIf.sv
regFile.sv
operandStage.sv
aluExec.sv
wbArbiter.sv
sdlxDatapath.sv
tbSdlx.sv

/* Makefile */
SRCS := $(shell grep -v '^+' sources.f) sdlx_consts.svh

.PHONY: all run clean

all: run

obj_dir/VtbSdlx: $(SRCS) sources.f
	verilator --binary --timing --assert --top-module tbSdlx -f sources.f -o VtbSdlx

run: obj_dir/VtbSdlx
	./obj_dir/VtbSdlx | tee sim.log
	grep -qF "*** PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log
